// File: verif/precompute_golden.txt
// opcode wa ra0 ra1 imm wdata in hex, opcode 0 AND 1 NOT 2 OR 3 XOR 4 ADD 5 SUB
// 6 MOV0 7 MOV1 8 MOVI and 9 undefined which runs as MOV0
8 0 0 0 1234 00001234
8 1 0 0 00ff 000000ff
8 2 0 0 f0f0 0000f0f0
8 3 0 0 0001 00000001
8 4 0 0 8000 00008000
8 5 0 0 ffff 0000ffff
8 6 0 0 0003 00000003
8 7 0 0 a5a5 0000a5a5
1 6 3 3 0000 fffffffe
4 7 6 3 0000 ffffffff
4 0 7 6 0000 fffffffd
5 1 3 0 0000 00000004
5 2 1 5 0000 ffff0005
0 3 2 5 0000 00000005
2 4 1 4 0000 00008004
3 5 4 2 0000 ffff8001
6 6 5 4 0000 ffff8001
7 7 0 4 0000 00008004
8 0 0 0 7fff 00007fff
4 1 0 0 0000 0000fffe
5 2 0 1 0000 ffff8001
1 3 2 2 0000 00007ffe
3 4 3 7 0000 0000fffa
0 5 4 3 0000 00007ffa
9 6 5 0 0000 00007ffa
4 7 6 5 0000 0000fff4

// File: sources.f
+incdir+hw
hw/pipe_pkg.sv
hw/inst_queue.sv
hw/reg_file.sv
hw/issue_stage.sv
hw/exec_unit.sv
hw/precompute_pipe.sv
verif/precompute_pipe_assert.sv
verif/tb_precompute_pipe.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

TOP=tb_precompute_pipe
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: verif/tb_precompute_pipe.sv
////////////////////////////////////////
// testbench for precompute_pipe with
// golden stimulus, scoreboard, watchdog
////////////////////////////////////////
`timescale 1ns/100ps
`include "pipe_settings.svh"

module tb_precompute_pipe import pipe_pkg::*; ();

  localparam int MAX_INSTR = 64;
  // cycles allowed per golden line
  localparam int CYCLE_LIMIT = 40;

  logic    clk;
  logic    rst;
  logic    in_pass;
  opcode_t in_op;
  reg_t    in_ra0;
  reg_t    in_ra1;
  reg_t    in_wa;
  imm_t    in_imm;
  logic    hold;
  logic    in_accept;
  logic    out_vld;
  reg_t    out_wa;
  word_t   out_wdata;

  // golden table with one entry per file line
  logic [3:0] gold_op [MAX_INSTR];
  reg_t       gold_wa [MAX_INSTR];
  reg_t       gold_ra0 [MAX_INSTR];
  reg_t       gold_ra1 [MAX_INSTR];
  imm_t       gold_imm [MAX_INSTR];
  word_t      gold_wdata [MAX_INSTR];
  int         n_instr;
  logic       loaded;

  // expected results in acceptance order
  reg_t  exp_wa_q [$];
  word_t exp_wdata_q [$];
  reg_t  exp_wa;
  word_t exp_wdata;

  int          next_idx;
  int          out_cnt;
  int          value_errs;
  int          other_errs;
  logic        accept_smp;
  logic        hold_prev;
  logic [31:0] lfsr;

  precompute_pipe i_precompute_pipe (
    .clk       (clk),
    .rst       (rst),
    .in_pass   (in_pass),
    .in_op     (in_op),
    .in_ra0    (in_ra0),
    .in_ra1    (in_ra1),
    .in_wa     (in_wa),
    .in_imm    (in_imm),
    .hold      (hold),
    .in_accept (in_accept),
    .out_vld   (out_vld),
    .out_wa    (out_wa),
    .out_wdata (out_wdata)
  );

  bind precompute_pipe precompute_pipe_assert i_pipe_assert (
    .clk       (clk),
    .rst       (rst),
    .hold      (hold),
    .in_pass   (in_pass),
    .in_accept (in_accept),
    .out_vld   (out_vld)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fibonacci taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // high only when two fresh bits are both set
  function automatic logic draw_hold();
    logic b0;
    logic b1;
    lfsr = lfsr_step(lfsr);
    b0 = lfsr[0];
    lfsr = lfsr_step(lfsr);
    b1 = lfsr[0];
    return b0 & b1;
  endfunction

  task automatic load_golden();
    int          fd;
    int          code;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_wa;
    logic [31:0] f_ra0;
    logic [31:0] f_ra1;
    logic [31:0] f_imm;
    logic [31:0] f_wd;
    n_instr = 0;
    fd = $fopen("verif/precompute_golden.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd) && n_instr < MAX_INSTR) begin
      code = $fgets(line, fd);
      // comment lines scan zero fields
      if (code > 0 &&
          $sscanf(line, "%h %h %h %h %h %h", f_op, f_wa, f_ra0, f_ra1, f_imm, f_wd) == 6) begin
        gold_op[n_instr]    = f_op[3:0];
        gold_wa[n_instr]    = f_wa[`PP_REG_W-1:0];
        gold_ra0[n_instr]   = f_ra0[`PP_REG_W-1:0];
        gold_ra1[n_instr]   = f_ra1[`PP_REG_W-1:0];
        gold_imm[n_instr]   = f_imm[`PP_IMM_W-1:0];
        gold_wdata[n_instr] = f_wd[`PP_WORD_W-1:0];
        n_instr++;
      end
    end
    $fclose(fd);
  endtask

  // check whether the last offer was taken and then offer the next line
  task automatic drive_cycle(input logic hold_val);
    @(negedge clk);
    accept_smp = in_accept;
    @(posedge clk);
    if (in_pass && accept_smp) begin
      exp_wa_q.push_back(gold_wa[next_idx]);
      exp_wdata_q.push_back(gold_wdata[next_idx]);
      next_idx++;
    end
    hold <= hold_val;
    if (next_idx < n_instr) begin
      in_pass <= 1'b1;
      in_op   <= opcode_t'(gold_op[next_idx]);
      in_wa   <= gold_wa[next_idx];
      in_ra0  <= gold_ra0[next_idx];
      in_ra1  <= gold_ra1[next_idx];
      in_imm  <= gold_imm[next_idx];
    end else begin
      in_pass <= 1'b0;
    end
  endtask

  // writeback monitor
  always @(negedge clk) begin
    if (out_vld === 1'b1) begin
      out_cnt++;
      if (hold_prev) begin
        other_errs++;
        $display("out_vld came in the cycle right after a hold cycle");
      end
      if (exp_wa_q.size() == 0) begin
        other_errs++;
        $display("a result retired with no instruction outstanding");
      end else begin
        exp_wa = exp_wa_q.pop_front();
        exp_wdata = exp_wdata_q.pop_front();
        if (out_wa !== exp_wa) begin
          value_errs++;
          $display("** Error: out_wa = 0x%h, expected 0x%h", out_wa, exp_wa);
        end
        if (out_wdata !== exp_wdata) begin
          value_errs++;
          $display("** Error: out_wdata = 0x%h, expected 0x%h", out_wdata, exp_wdata);
        end
      end
    end
    hold_prev = hold;
  end

  initial begin
    int guard;
    rst     <= 1'b1;
    in_pass <= 1'b0;
    in_op   <= OP_MOV0;
    in_ra0  <= '0;
    in_ra1  <= '0;
    in_wa   <= '0;
    in_imm  <= '0;
    hold    <= 1'b0;
    loaded = 1'b0;
    next_idx = 0;
    out_cnt = 0;
    value_errs = 0;
    other_errs = 0;
    hold_prev = 1'b0;
    lfsr = 32'hc96a_fbba;
    load_golden();
    if (n_instr == 0) begin
      $display("could not read any instruction from the golden file");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      if (out_vld !== 1'b0) begin
        value_errs++;
        $display("** Error: out_vld = 0x%h, expected 0x%h", out_vld, 1'b0);
      end
      if (in_accept !== 1'b1) begin
        value_errs++;
        $display("** Error: in_accept = 0x%h, expected 0x%h", in_accept, 1'b1);
      end

      // freeze the empty pipeline and fill the queue
      guard = 0;
      do begin
        drive_cycle(1'b1);
        guard++;
      end while (accept_smp && guard < 4 * `PP_QUEUE_DEPTH);
      if (accept_smp) begin
        other_errs++;
        $display("in_accept never went low while hold kept the queue full");
      end
      repeat (4) begin
        drive_cycle(1'b1);
        if (accept_smp) begin
          other_errs++;
          $display("in_accept rose while the queue was full and frozen");
        end
      end
      if (next_idx != `PP_QUEUE_DEPTH) begin
        other_errs++;
        $display("queue took %0d pushes under hold, expected %0d", next_idx, `PP_QUEUE_DEPTH);
      end
      if (out_cnt != 0) begin
        other_errs++;
        $display("%0d results retired while hold was forced high", out_cnt);
      end

      // rest of the list under random hold
      while (next_idx < n_instr) begin
        drive_cycle(draw_hold());
      end
      while (out_cnt < n_instr) begin
        drive_cycle(draw_hold());
      end
      // a few idle cycles to catch duplicates
      repeat (8) drive_cycle(1'b0);
      if (out_cnt != n_instr) begin
        other_errs++;
        $display("saw %0d results, expected %0d", out_cnt, n_instr);
      end
      if (exp_wa_q.size() != 0) begin
        other_errs++;
        $display("%0d accepted instructions never retired", exp_wa_q.size());
      end

      $display("errors: %0d value, %0d other, results %0d of %0d",
               value_errs, other_errs, out_cnt, n_instr);
      if (value_errs + other_errs == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

  // watchdog sized from the golden list
  initial begin
    wait (loaded === 1'b1);
    repeat (n_instr * CYCLE_LIMIT) @(posedge clk);
    $display("watchdog expired after %0d cycles with %0d of %0d results",
             n_instr * CYCLE_LIMIT, out_cnt, n_instr);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: verif/precompute_pipe_assert.sv
////////////////////////////////////////
// concurrent checks on the top level
// ports, attached by bind
////////////////////////////////////////
`timescale 1ns/100ps

module precompute_pipe_assert (
  input logic clk,
  input logic rst,
  input logic hold,
  input logic in_pass,
  input logic in_accept,
  input logic out_vld
);

  // frozen pipeline retires nothing on the next cycle
  hold_blocks_retire: assert property (
    @(posedge clk) disable iff (rst) hold |=> !out_vld
  ) else $error("out_vld high after a hold cycle");

  // queue starts empty
  ready_after_reset: assert property (
    @(posedge clk) $fell(rst) |-> in_accept
  ) else $error("in_accept low in the first cycle after reset");

  // full flag only sets behind a push
  full_needs_push: assert property (
    @(posedge clk) disable iff (rst) $fell(in_accept) |-> $past(in_pass)
  ) else $error("in_accept fell without a push");

endmodule

// File: hw/precompute_pipe.sv
////////////////////////////////////////
// top level, queue to s1/s2 issue to
// execute, with the register file
////////////////////////////////////////
`timescale 1ns/100ps

module precompute_pipe import pipe_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_pass,
  input  opcode_t in_op,
  input  reg_t    in_ra0,
  input  reg_t    in_ra1,
  input  reg_t    in_wa,
  input  imm_t    in_imm,
  input  logic    hold,
  output logic    in_accept,
  output logic    out_vld,
  output reg_t    out_wa,
  output word_t   out_wdata
);

  // queue head
  logic     q_vld;
  opcode_t  q_op;
  reg_t     q_ra0;
  reg_t     q_ra1;
  reg_t     q_wa;
  imm_t     q_imm;
  logic     pop;
  // register file read side
  logic     ren;
  reg_t     rf_ra0;
  reg_t     rf_ra1;
  word_t    rdata0;
  word_t    rdata1;
  // s2 into execute
  logic     s2_vld;
  opcode_t  s2_op;
  reg_t     s2_wa;
  imm_t     s2_imm;
  fwd_sel_t s2_fwd0;
  fwd_sel_t s2_fwd1;
  // register file write from s3
  logic     wen;
  reg_t     wa;
  word_t    wdata;

  inst_queue i_inst_queue (
    .clk       (clk),
    .rst       (rst),
    .in_pass   (in_pass),
    .in_op     (in_op),
    .in_ra0    (in_ra0),
    .in_ra1    (in_ra1),
    .in_wa     (in_wa),
    .in_imm    (in_imm),
    .pop       (pop),
    .in_accept (in_accept),
    .q_vld     (q_vld),
    .q_op      (q_op),
    .q_ra0     (q_ra0),
    .q_ra1     (q_ra1),
    .q_wa      (q_wa),
    .q_imm     (q_imm)
  );

  issue_stage i_issue_stage (
    .clk     (clk),
    .rst     (rst),
    .hold    (hold),
    .q_vld   (q_vld),
    .q_op    (q_op),
    .q_ra0   (q_ra0),
    .q_ra1   (q_ra1),
    .q_wa    (q_wa),
    .q_imm   (q_imm),
    .pop     (pop),
    .ren     (ren),
    .rf_ra0  (rf_ra0),
    .rf_ra1  (rf_ra1),
    .s2_vld  (s2_vld),
    .s2_op   (s2_op),
    .s2_wa   (s2_wa),
    .s2_imm  (s2_imm),
    .s2_fwd0 (s2_fwd0),
    .s2_fwd1 (s2_fwd1)
  );

  reg_file i_reg_file (
    .clk    (clk),
    .ren    (ren),
    .ra0    (rf_ra0),
    .ra1    (rf_ra1),
    .wen    (wen),
    .wa     (wa),
    .wdata  (wdata),
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

  exec_unit i_exec_unit (
    .clk       (clk),
    .rst       (rst),
    .hold      (hold),
    .s2_vld    (s2_vld),
    .s2_op     (s2_op),
    .s2_wa     (s2_wa),
    .s2_imm    (s2_imm),
    .s2_fwd0   (s2_fwd0),
    .s2_fwd1   (s2_fwd1),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .wen       (wen),
    .wa        (wa),
    .wdata     (wdata),
    .out_vld   (out_vld),
    .out_wa    (out_wa),
    .out_wdata (out_wdata)
  );

endmodule

// File: hw/exec_unit.sv
////////////////////////////////////////
// operand select, ALU, s3 register
// and writeback port
////////////////////////////////////////
`timescale 1ns/100ps

module exec_unit import pipe_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,
  input  logic     s2_vld,
  input  opcode_t  s2_op,
  input  reg_t     s2_wa,
  input  imm_t     s2_imm,
  input  fwd_sel_t s2_fwd0,
  input  fwd_sel_t s2_fwd1,
  input  word_t    rdata0,
  input  word_t    rdata1,
  output logic     wen,
  output reg_t     wa,
  output word_t    wdata,
  output logic     out_vld,
  output reg_t     out_wa,
  output word_t    out_wdata
);

  word_t opa;
  word_t opb;
  word_t alu_res;
  // s3 stage
  logic  s3_vld;
  reg_t  s3_wa;
  word_t s3_wdata;

  // operand mux with a select that settled a stage earlier
  assign opa = (s2_fwd0 == FWD_S3) ? s3_wdata : rdata0;
  assign opb = (s2_fwd1 == FWD_S3) ? s3_wdata : rdata1;

  always_comb begin
    case (s2_op)
      OP_AND:  alu_res = opa & opb;
      OP_NOT:  alu_res = ~opa;
      OP_OR:   alu_res = opa | opb;
      OP_XOR:  alu_res = opa ^ opb;
      // add and sub wrap at word width
      OP_ADD:  alu_res = opa + opb;
      OP_SUB:  alu_res = opa - opb;
      OP_MOV0: alu_res = opa;
      OP_MOV1: alu_res = opb;
      OP_MOVI: alu_res = word_t'(s2_imm);
      default: alu_res = opa;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s3_vld <= 1'b0;
    end else if (!hold) begin
      s3_vld <= s2_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      s3_wa    <= s2_wa;
      s3_wdata <= alu_res;
    end
  end

  // retire from s3 with no write while frozen
  assign wen   = s3_vld & ~hold;
  assign wa    = s3_wa;
  assign wdata = s3_wdata;

  // one-cycle strobe per retired instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= wen;
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      out_wa    <= s3_wa;
      out_wdata <= s3_wdata;
    end
  end

endmodule

// File: hw/issue_stage.sv
////////////////////////////////////////
// s1 and s2 stage registers, register
// file read and forwarding precompute
////////////////////////////////////////
`timescale 1ns/100ps

module issue_stage import pipe_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,
  input  logic     q_vld,
  input  opcode_t  q_op,
  input  reg_t     q_ra0,
  input  reg_t     q_ra1,
  input  reg_t     q_wa,
  input  imm_t     q_imm,
  output logic     pop,
  output logic     ren,
  output reg_t     rf_ra0,
  output reg_t     rf_ra1,
  output logic     s2_vld,
  output opcode_t  s2_op,
  output reg_t     s2_wa,
  output imm_t     s2_imm,
  output fwd_sel_t s2_fwd0,
  output fwd_sel_t s2_fwd1
);

  // s1 stage
  logic     s1_vld;
  opcode_t  s1_op;
  reg_t     s1_ra0;
  reg_t     s1_ra1;
  reg_t     s1_wa;
  imm_t     s1_imm;
  // selects computed in s1, used in s2
  fwd_sel_t s1_fwd0;
  fwd_sel_t s1_fwd1;

  assign pop = q_vld & ~hold;

  // read issued as s1 moves on and data lands with s2
  assign ren    = s1_vld & ~hold;
  assign rf_ra0 = s1_ra0;
  assign rf_ra1 = s1_ra1;

  // s2 producer will sit in s3 when this one reaches s2
  // older producers come through the register file
  always_comb begin
    s1_fwd0 = (s2_vld && (s2_wa == s1_ra0)) ? FWD_S3 : FWD_RF;
    s1_fwd1 = (s2_vld && (s2_wa == s1_ra1)) ? FWD_S3 : FWD_RF;
  end

  // bubbles travel as cleared valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
    end else if (!hold) begin
      s1_vld <= pop;
      s2_vld <= s1_vld;
    end
  end

  // payload is meaningful only with its valid bit
  always_ff @(posedge clk) begin
    if (!hold) begin
      s1_op   <= q_op;
      s1_ra0  <= q_ra0;
      s1_ra1  <= q_ra1;
      s1_wa   <= q_wa;
      s1_imm  <= q_imm;
      s2_op   <= s1_op;
      s2_wa   <= s1_wa;
      s2_imm  <= s1_imm;
      s2_fwd0 <= s1_fwd0;
      s2_fwd1 <= s1_fwd1;
    end
  end

endmodule

// File: hw/reg_file.sv
////////////////////////////////////////
// register file, 2 flopped read ports,
// 1 write port with write-through
////////////////////////////////////////
`timescale 1ns/100ps

module reg_file import pipe_pkg::*; (
  input  logic  clk,
  input  logic  ren,
  input  reg_t  ra0,
  input  reg_t  ra1,
  input  logic  wen,
  input  reg_t  wa,
  input  word_t wdata,
  output word_t rdata0,
  output word_t rdata1
);

  localparam int N_REGS = 1 << $bits(reg_t);

  word_t mem [N_REGS];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[wa] <= wdata;
    end
  end

  // read data held while ren is low
  // same-cycle write to the read address returns the new value
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata0 <= (wen && (wa == ra0)) ? wdata : mem[ra0];
      rdata1 <= (wen && (wa == ra1)) ? wdata : mem[ra1];
    end
  end

endmodule

// File: hw/inst_queue.sv
////////////////////////////////////////
// instruction queue, circular buffer
// with registered full and empty flags
////////////////////////////////////////
`timescale 1ns/100ps
`include "pipe_settings.svh"

module inst_queue import pipe_pkg::*; #(
  parameter int DEPTH = `PP_QUEUE_DEPTH
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_pass,
  input  opcode_t in_op,
  input  reg_t    in_ra0,
  input  reg_t    in_ra1,
  input  reg_t    in_wa,
  input  imm_t    in_imm,
  input  logic    pop,
  output logic    in_accept,
  output logic    q_vld,
  output opcode_t q_op,
  output reg_t    q_ra0,
  output reg_t    q_ra1,
  output reg_t    q_wa,
  output imm_t    q_imm
);

  localparam int AW = $clog2(DEPTH);

  // entry storage
  opcode_t op_mem [DEPTH];
  reg_t    ra0_mem [DEPTH];
  reg_t    ra1_mem [DEPTH];
  reg_t    wa_mem [DEPTH];
  imm_t    imm_mem [DEPTH];

  // pointers carry a wrap bit on top
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] wr_ptr_nxt;
  logic [AW:0] rd_ptr_nxt;
  logic        push;
  logic        full_r;
  logic        empty_r;

  assign push = in_pass & in_accept;
  assign wr_ptr_nxt = wr_ptr + {{AW{1'b0}}, push};
  // pop only ever comes with q_vld high
  assign rd_ptr_nxt = rd_ptr + {{AW{1'b0}}, pop};

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      rd_ptr  <= rd_ptr_nxt;
      // flags from the next pointers, so they line up with them
      empty_r <= (rd_ptr_nxt == wr_ptr_nxt);
      full_r  <= (rd_ptr_nxt[AW] != wr_ptr_nxt[AW]) &&
                 (rd_ptr_nxt[AW-1:0] == wr_ptr_nxt[AW-1:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr[AW-1:0]]  <= in_op;
      ra0_mem[wr_ptr[AW-1:0]] <= in_ra0;
      ra1_mem[wr_ptr[AW-1:0]] <= in_ra1;
      wa_mem[wr_ptr[AW-1:0]]  <= in_wa;
      imm_mem[wr_ptr[AW-1:0]] <= in_imm;
    end
  end

  assign in_accept = ~full_r;

  // head presented combinationally
  assign q_vld = ~empty_r;
  assign q_op  = op_mem[rd_ptr[AW-1:0]];
  assign q_ra0 = ra0_mem[rd_ptr[AW-1:0]];
  assign q_ra1 = ra1_mem[rd_ptr[AW-1:0]];
  assign q_wa  = wa_mem[rd_ptr[AW-1:0]];
  assign q_imm = imm_mem[rd_ptr[AW-1:0]];

endmodule

// File: hw/pipe_pkg.sv
////////////////////////////////////////
// pipeline typedefs, opcode and
// operand source encodings
////////////////////////////////////////
`include "pipe_settings.svh"

package pipe_pkg;

  typedef logic [`PP_WORD_W-1:0] word_t;
  typedef logic [`PP_REG_W-1:0]  reg_t;
  // zero-extended by MOVI
  typedef logic [`PP_IMM_W-1:0]  imm_t;

  // codes 9..15 are undefined and execute as MOV0
  typedef enum logic [3:0] {
    OP_AND  = 4'd0,
    OP_NOT  = 4'd1,
    OP_OR   = 4'd2,
    OP_XOR  = 4'd3,
    OP_ADD  = 4'd4,
    OP_SUB  = 4'd5,
    OP_MOV0 = 4'd6,
    OP_MOV1 = 4'd7,
    OP_MOVI = 4'd8
  } opcode_t;

  // operand source in s2
  typedef enum logic {
    FWD_RF = 1'b0,
    FWD_S3 = 1'b1
  } fwd_sel_t;

endpackage

// File: hw/pipe_settings.svh
////////////////////////////////////////
// datapath widths and queue depth
////////////////////////////////////////
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// data word
`define PP_WORD_W 32
// eight registers, so hazards come often
`define PP_REG_W 3
`define PP_IMM_W 16
// must stay a power of two
`define PP_QUEUE_DEPTH 16

`endif
